/* sim.f */
source/pipeline_tail_pkg.sv
source/frame_buffer.sv
source/drawing_manager.sv
source/buffer_swap_ctrl.sv
source/display_scan.sv
source/pipeline_tail.sv
tests/pipeline_tail_props.sv
tests/pipeline_tail_tb.sv

/* Makefile */
SIM_BIN := obj_dir/Vpipeline_tail_tb

.PHONY: all run clean

all: run

$(SIM_BIN): sim.f $(wildcard source/*.sv) $(wildcard tests/*.sv)
	verilator --binary --timing --assert -f sim.f --top-module pipeline_tail_tb \
		-o Vpipeline_tail_tb

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
		echo "$$out" | grep -q "^Simulation PASSED$$"

clean:
	rm -rf obj_dir

/* tests/pipeline_tail_tb.sv */
`timescale 1ns/1ps

module pipeline_tail_tb;

    localparam int BUF_W       = 8;
    localparam int BUF_H       = 4;
    localparam int SCALE_SHIFT = 1;
    localparam int H_ACTIVE    = 16;
    localparam int H_FRONT     = 2;
    localparam int H_SYNC      = 3;
    localparam int H_BACK      = 2;
    localparam int V_ACTIVE    = 8;
    localparam int V_FRONT     = 1;
    localparam int V_SYNC      = 2;
    localparam int V_BACK      = 1;
    localparam int H_TOTAL     = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL     = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int NPIX        = BUF_W * BUF_H;
    // Lock, three frames streamed and displayed, plus slack
    localparam int TIMEOUT_CYCLES = 12 * H_TOTAL * V_TOTAL + 100;

    logic                           clk_display = 1'b0;
    logic                           rstn_display;
    logic                           pixel_valid;
    pipeline_tail_pkg::pixel_beat_t pixel_beat;
    logic                           pixel_ready;
    logic                           vga_hsync;
    logic                           vga_vsync;
    pipeline_tail_pkg::color_t      vga_red;
    pipeline_tail_pkg::color_t      vga_green;
    pipeline_tail_pkg::color_t      vga_blue;

    int          mismatch_count = 0;
    int          fail_count     = 0;
    logic [31:0] rng_state      = 32'd35;

    // Scan tracking and reference frame state
    logic locked = 1'b0;
    int   h = 0;
    int   v = 0;
    logic prev_hs = 1'b1;
    logic prev_vs = 1'b1;
    logic hs_seen = 1'b0;
    logic vs_seen = 1'b0;
    int   hs_low = 0;
    int   hs_per = 0;
    int   vs_low = 0;
    int   vs_per = 0;
    pipeline_tail_pkg::pixel_t draw_buf [NPIX];
    pipeline_tail_pkg::pixel_t pending_buf [NPIX];
    pipeline_tail_pkg::pixel_t shown_buf [NPIX];
    logic shown_valid = 1'b0;
    int   shown_id = 0;
    int   pending_id = 0;
    int   final_frames = 0;
    logic req_model = 1'b0;
    logic hold = 1'b0;
    logic swapped = 1'b0;
    logic ready_check = 1'b0;
    int   wr_addr = 0;
    int   beats = 0;

    always #10 clk_display = !clk_display;

    pipeline_tail #(
        .BUF_W (BUF_W), .BUF_H (BUF_H), .SCALE_SHIFT (SCALE_SHIFT),
        .H_ACTIVE (H_ACTIVE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_BACK (H_BACK),
        .V_ACTIVE (V_ACTIVE), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC), .V_BACK (V_BACK)
    ) i_pipeline_tail (
        .clk_display  (clk_display),
        .rstn_display (rstn_display),
        .pixel_valid  (pixel_valid),
        .pixel_beat   (pixel_beat),
        .pixel_ready  (pixel_ready),
        .vga_hsync    (vga_hsync),
        .vga_vsync    (vga_vsync),
        .vga_red      (vga_red),
        .vga_green    (vga_green),
        .vga_blue     (vga_blue)
    );

    //////////////////////////////////////////////////
    // Reference model and compare tasks
    //////////////////////////////////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Each stored pixel covers a square of 2^SCALE_SHIFT screen pixels
    function automatic pipeline_tail_pkg::pixel_t expected_pixel(
        input int hp, input int vp, input pipeline_tail_pkg::pixel_t frame [NPIX]);
        return frame[(vp >> SCALE_SHIFT) * BUF_W + (hp >> SCALE_SHIFT)];
    endfunction

    task automatic check_pixel(input string name, input pipeline_tail_pkg::pixel_t exp,
                               input pipeline_tail_pkg::pixel_t act);
        if (exp !== act) begin
            mismatch_count++;
            $display("MISMATCH %s expected %h actual %h (h=%0d v=%0d)", name, exp, act, h, v);
        end
    endtask

    task automatic check_color(input string name, input pipeline_tail_pkg::color_t exp,
                               input pipeline_tail_pkg::color_t act);
        if (exp !== act) begin
            mismatch_count++;
            $display("MISMATCH %s expected %h actual %h (h=%0d v=%0d)", name, exp, act, h, v);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp != act) begin
            mismatch_count++;
            $display("MISMATCH %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    //////////////////////////////////////////////////
    // Monitor, sampled on the falling edge
    //////////////////////////////////////////////////

    always @(negedge clk_display) begin
        if (rstn_display) begin
            if (locked) begin
                h++;
                if (h == H_TOTAL) begin
                    h = 0;
                    v = (v == V_TOTAL - 1) ? 0 : v + 1;
                end
            end
            hs_per++;
            vs_per++;
            if (!vga_hsync) hs_low++;
            if (!vga_vsync) vs_low++;
            if (prev_hs && !vga_hsync) begin
                if (locked) check_count("hsync position", H_ACTIVE + H_FRONT, h);
                if (hs_seen) check_count("hsync period", H_TOTAL, hs_per);
                hs_seen = 1'b1;
                hs_per  = 0;
            end
            if (!prev_hs && vga_hsync) begin
                check_count("hsync width", H_SYNC, hs_low);
                hs_low = 0;
            end
            // Vsync falls at pixel 0 of the first sync line
            if (prev_vs && !vga_vsync) begin
                if (locked) check_count("vsync line", V_ACTIVE + V_FRONT, v);
                if (vs_seen) check_count("vsync period", H_TOTAL * V_TOTAL, vs_per);
                vs_seen = 1'b1;
                vs_per  = 0;
                locked  = 1'b1;
                h       = 0;
                v       = V_ACTIVE + V_FRONT;
            end
            if (!prev_vs && vga_vsync) begin
                check_count("vsync width", V_SYNC * H_TOTAL, vs_low);
                vs_low = 0;
            end
            if (locked) begin
                if (h < H_ACTIVE && v < V_ACTIVE) begin
                    if (shown_valid) begin
                        check_pixel("active pixel", expected_pixel(h, v, shown_buf),
                                    {vga_red, vga_green, vga_blue});
                    end
                end else begin
                    check_color("blank red", '0, vga_red);
                    check_color("blank green", '0, vga_green);
                    check_color("blank blue", '0, vga_blue);
                end
                // Outputs lag the counters by two, so the counters sit at blank start
                if (h == H_TOTAL - 2 && v == V_ACTIVE - 1) begin
                    if (shown_id == 3) final_frames++;
                    if (req_model) begin
                        shown_buf   = pending_buf;
                        shown_id    = pending_id;
                        shown_valid = 1'b1;
                        req_model   = 1'b0;
                        swapped     = 1'b1;
                    end
                end
            end
            if (ready_check) begin
                check_count("ready after eof", 0, int'(pixel_ready));
                ready_check = 1'b0;
            end
            if (pixel_valid && pixel_ready) begin
                if (hold && !swapped) begin
                    fail_count++;
                    $display("ERROR: a beat was accepted before the buffers were swapped");
                end
                hold = 1'b0;
                if (pixel_beat.meta.sof) begin
                    wr_addr = 0;
                    beats   = 0;
                end
                draw_buf[wr_addr] = pixel_beat.pixel;
                wr_addr++;
                beats++;
                if (pixel_beat.meta.eof) begin
                    check_count("beats per frame", NPIX, beats);
                    pending_buf = draw_buf;
                    pending_id++;
                    req_model   = 1'b1;
                    hold        = 1'b1;
                    swapped     = 1'b0;
                    ready_check = 1'b1;
                    wr_addr     = 0;
                    beats       = 0;
                end
            end
            prev_hs = vga_hsync;
            prev_vs = vga_vsync;
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    task automatic send_beat(input logic sof, input logic eof);
        logic acc;
        acc = 1'b0;
        rng_state = xorshift(rng_state);
        if (rng_state[1:0] == 2'b00) begin
            pixel_valid = 1'b0;
            @(posedge clk_display);
            #1;
        end
        rng_state = xorshift(rng_state);
        pixel_valid          = 1'b1;
        pixel_beat.pixel     = rng_state[11:0];
        pixel_beat.meta.sof  = sof;
        pixel_beat.meta.eof  = eof;
        while (!acc) begin
            @(negedge clk_display);
            acc = pixel_ready;
            @(posedge clk_display);
            #1;
        end
        pixel_valid = 1'b0;
    endtask

    task automatic send_frame(input int count, input logic with_eof);
        for (int i = 0; i < count; i++) begin
            send_beat(i == 0, with_eof && (i == count - 1));
        end
    endtask

    task automatic report_end(input logic timed_out);
        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
        if (!timed_out && mismatch_count == 0 && fail_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
    endtask

    initial begin
        rstn_display = 1'b0;
        pixel_valid  = 1'b0;
        pixel_beat   = '0;
        repeat (10) @(posedge clk_display);
        #1;
        rstn_display = 1'b1;
        wait (locked);
        @(posedge clk_display);
        #1;
        send_frame(NPIX, 1'b1);
        // Frame 2 streams while frame 1 is on screen
        send_frame(NPIX, 1'b1);
        // Frame 3 is cut short and restarted with sof
        send_frame(13, 1'b0);
        send_frame(NPIX, 1'b1);
        wait (final_frames >= 1);
        report_end(1'b0);
        $finish;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk_display);
        $display("ERROR: timeout, the run did not finish in %0d cycles", TIMEOUT_CYCLES);
        report_end(1'b1);
        $finish;
    end

endmodule

/* tests/pipeline_tail_props.sv */
`timescale 1ns/1ps

module pipeline_tail_props (
    input logic clk_display,
    input logic rstn_display,
    input logic blank_start,
    input logic swap_req,
    input logic swap_ack,
    input logic front_sel
);

    // Request is held until answered
    req_held: assert property (@(posedge clk_display) disable iff (!rstn_display)
        (swap_req && !swap_ack) |=> swap_req)
        else $error("swap_req dropped before swap_ack");

    ack_rise_with_req: assert property (@(posedge clk_display) disable iff (!rstn_display)
        $rose(swap_ack) |-> swap_req)
        else $error("swap_ack rose without swap_req");

    // Buffers never change during active video
    sel_on_blank: assert property (@(posedge clk_display) disable iff (!rstn_display)
        (front_sel != $past(front_sel)) |-> $past(blank_start))
        else $error("front_sel changed away from blank_start");

endmodule

bind buffer_swap_ctrl pipeline_tail_props i_pipeline_tail_props (
    .clk_display  (clk_display),
    .rstn_display (rstn_display),
    .blank_start  (blank_start),
    .swap_req     (swap_req),
    .swap_ack     (swap_ack),
    .front_sel    (front_sel)
);

/* source/pipeline_tail.sv */
`timescale 1ns/1ps

module pipeline_tail #(
    parameter int BUF_W       = 160,
    parameter int BUF_H       = 120,
    parameter int SCALE_SHIFT = 2,
    parameter int H_ACTIVE    = 640,
    parameter int H_FRONT     = 16,
    parameter int H_SYNC      = 96,
    parameter int H_BACK      = 48,
    parameter int V_ACTIVE    = 480,
    parameter int V_FRONT     = 10,
    parameter int V_SYNC      = 2,
    parameter int V_BACK      = 33
) (
    input  logic                           clk_display,
    input  logic                           rstn_display,

    // Pixel stream in
    input  logic                           pixel_valid,
    input  pipeline_tail_pkg::pixel_beat_t pixel_beat,
    output logic                           pixel_ready,

    // VGA out
    output logic                           vga_hsync,
    output logic                           vga_vsync,
    output pipeline_tail_pkg::color_t      vga_red,
    output pipeline_tail_pkg::color_t      vga_green,
    output pipeline_tail_pkg::color_t      vga_blue
);

    localparam int DEPTH  = BUF_W * BUF_H;
    localparam int ADDR_W = $clog2(DEPTH);

    pipeline_tail_pkg::fb_write_t fb_wr;
    pipeline_tail_pkg::fb_write_t fb_a_wr;
    pipeline_tail_pkg::fb_write_t fb_b_wr;
    pipeline_tail_pkg::pixel_t    fb_a_rd_data;
    pipeline_tail_pkg::pixel_t    fb_b_rd_data;
    pipeline_tail_pkg::pixel_t    rd_data;
    logic [ADDR_W-1:0]            rd_addr;
    logic                         front_sel;
    logic                         swap_req;
    logic                         swap_ack;
    logic                         blank_start;

    //////////////////////////////////////////////////
    // Drawing side
    //////////////////////////////////////////////////

    drawing_manager i_drawing_manager (
        .clk_display  (clk_display),
        .rstn_display (rstn_display),
        .pixel_valid  (pixel_valid),
        .pixel_beat   (pixel_beat),
        .pixel_ready  (pixel_ready),
        .fb_wr        (fb_wr),
        .swap_req     (swap_req),
        .swap_ack     (swap_ack)
    );

    buffer_swap_ctrl i_buffer_swap_ctrl (
        .clk_display  (clk_display),
        .rstn_display (rstn_display),
        .blank_start  (blank_start),
        .swap_req     (swap_req),
        .swap_ack     (swap_ack),
        .front_sel    (front_sel)
    );

    //////////////////////////////////////////////////
    // Buffer routing
    //////////////////////////////////////////////////

    // Writes only ever reach the buffer not on screen
    always_comb begin
        fb_a_wr    = fb_wr;
        fb_b_wr    = fb_wr;
        fb_a_wr.en = fb_wr.en && front_sel;
        fb_b_wr.en = fb_wr.en && !front_sel;
    end

    assign rd_data = front_sel ? fb_b_rd_data : fb_a_rd_data;

    frame_buffer #(
        .ADDR_W (ADDR_W),
        .DEPTH  (DEPTH)
    ) fb_a (
        .clk_display (clk_display),
        .wr          (fb_a_wr),
        .rd_addr     (rd_addr),
        .rd_data     (fb_a_rd_data)
    );

    frame_buffer #(
        .ADDR_W (ADDR_W),
        .DEPTH  (DEPTH)
    ) fb_b (
        .clk_display (clk_display),
        .wr          (fb_b_wr),
        .rd_addr     (rd_addr),
        .rd_data     (fb_b_rd_data)
    );

    //////////////////////////////////////////////////
    // Display side
    //////////////////////////////////////////////////

    display_scan #(
        .H_ACTIVE    (H_ACTIVE),
        .H_FRONT     (H_FRONT),
        .H_SYNC      (H_SYNC),
        .H_BACK      (H_BACK),
        .V_ACTIVE    (V_ACTIVE),
        .V_FRONT     (V_FRONT),
        .V_SYNC      (V_SYNC),
        .V_BACK      (V_BACK),
        .BUF_W       (BUF_W),
        .SCALE_SHIFT (SCALE_SHIFT),
        .ADDR_W      (ADDR_W)
    ) i_display_scan (
        .clk_display  (clk_display),
        .rstn_display (rstn_display),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .blank_start  (blank_start),
        .vga_hsync    (vga_hsync),
        .vga_vsync    (vga_vsync),
        .vga_red      (vga_red),
        .vga_green    (vga_green),
        .vga_blue     (vga_blue)
    );

endmodule

/* source/display_scan.sv */
`timescale 1ns/1ps

module display_scan #(
    parameter int H_ACTIVE    = 640,
    parameter int H_FRONT     = 16,
    parameter int H_SYNC      = 96,
    parameter int H_BACK      = 48,
    parameter int V_ACTIVE    = 480,
    parameter int V_FRONT     = 10,
    parameter int V_SYNC      = 2,
    parameter int V_BACK      = 33,
    parameter int BUF_W       = 160,
    parameter int SCALE_SHIFT = 2,
    parameter int ADDR_W      = 15
) (
    input  logic                      clk_display,
    input  logic                      rstn_display,

    // Frame buffer read side
    output logic [ADDR_W-1:0]         rd_addr,
    input  pipeline_tail_pkg::pixel_t rd_data,

    output logic                      blank_start,

    // VGA out, syncs active low
    output logic                      vga_hsync,
    output logic                      vga_vsync,
    output pipeline_tail_pkg::color_t vga_red,
    output pipeline_tail_pkg::color_t vga_green,
    output pipeline_tail_pkg::color_t vga_blue
);

    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int H_CNT_W = $clog2(H_TOTAL);
    localparam int V_CNT_W = $clog2(V_TOTAL);

    typedef logic [H_CNT_W-1:0] h_count_t;
    typedef logic [V_CNT_W-1:0] v_count_t;

    h_count_t h_cnt;
    v_count_t v_cnt;
    logic     active;
    logic     hsync;
    logic     vsync;
    logic     active_d;
    logic     hsync_d;
    logic     vsync_d;

    //////////////////////////////////////////////////
    // Free running counters
    //////////////////////////////////////////////////

    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == h_count_t'(H_TOTAL - 1)) begin
            h_cnt <= '0;
            if (v_cnt == v_count_t'(V_TOTAL - 1)) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Timing decode
    //////////////////////////////////////////////////

    assign active = (h_cnt < h_count_t'(H_ACTIVE)) && (v_cnt < v_count_t'(V_ACTIVE));

    // Sync pulse sits right after the front porch
    assign hsync = !((h_cnt >= h_count_t'(H_ACTIVE + H_FRONT)) &&
                     (h_cnt <  h_count_t'(H_ACTIVE + H_FRONT + H_SYNC)));
    assign vsync = !((v_cnt >= v_count_t'(V_ACTIVE + V_FRONT)) &&
                     (v_cnt <  v_count_t'(V_ACTIVE + V_FRONT + V_SYNC)));

    // First pixel of the first line below the picture
    assign blank_start = (h_cnt == '0) && (v_cnt == v_count_t'(V_ACTIVE));

    // Each stored pixel covers a 2^SCALE_SHIFT square on screen
    // Address parks at 0 outside the picture
    always_comb begin
        if (active) begin
            rd_addr = ADDR_W'((v_cnt >> SCALE_SHIFT) * BUF_W + (h_cnt >> SCALE_SHIFT));
        end else begin
            rd_addr = '0;
        end
    end

    //////////////////////////////////////////////////
    // Alignment with read data and output register
    //////////////////////////////////////////////////

    // Stage 1 matches the buffer's read latency
    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            active_d <= 1'b0;
            hsync_d  <= 1'b1;
            vsync_d  <= 1'b1;
        end else begin
            active_d <= active;
            hsync_d  <= hsync;
            vsync_d  <= vsync;
        end
    end

    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            vga_hsync <= 1'b1;
            vga_vsync <= 1'b1;
            vga_red   <= '0;
            vga_green <= '0;
            vga_blue  <= '0;
        end else begin
            vga_hsync <= hsync_d;
            vga_vsync <= vsync_d;
            vga_red   <= active_d ? rd_data[11:8] : '0;
            vga_green <= active_d ? rd_data[7:4]  : '0;
            vga_blue  <= active_d ? rd_data[3:0]  : '0;
        end
    end

endmodule

/* source/buffer_swap_ctrl.sv */
`timescale 1ns/1ps

module buffer_swap_ctrl (
    input  logic clk_display,
    input  logic rstn_display,

    // From the display scan
    input  logic blank_start,

    // Frame done handshake
    input  logic swap_req,
    output logic swap_ack,

    // 0 shows fb_a, 1 shows fb_b
    output logic front_sel
);

    logic take_swap;
    logic ack_pend;

    //////////////////////////////////////////////////
    // Swap on the first blank line only
    //////////////////////////////////////////////////

    // A request seen mid frame simply waits here for the next blank
    assign take_swap = blank_start && swap_req && !ack_pend && !swap_ack;

    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            front_sel <= 1'b0;
            ack_pend  <= 1'b0;
        end else begin
            if (take_swap) begin
                front_sel <= !front_sel;
            end
            ack_pend <= take_swap;
        end
    end

    //////////////////////////////////////////////////
    // Acknowledge and return to zero
    //////////////////////////////////////////////////

    // Ack follows the toggle by one cycle
    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            swap_ack <= 1'b0;
        end else if (ack_pend) begin
            swap_ack <= 1'b1;
        end else if (!swap_req) begin
            swap_ack <= 1'b0;
        end
    end

endmodule

/* source/drawing_manager.sv */
`timescale 1ns/1ps

module drawing_manager (
    input  logic                           clk_display,
    input  logic                           rstn_display,

    // Pixel stream in
    input  logic                           pixel_valid,
    input  pipeline_tail_pkg::pixel_beat_t pixel_beat,
    output logic                           pixel_ready,

    // Back buffer write port
    output pipeline_tail_pkg::fb_write_t   fb_wr,

    // Frame done handshake
    output logic                           swap_req,
    input  logic                           swap_ack
);

    pipeline_tail_pkg::draw_state_t state;
    pipeline_tail_pkg::draw_state_t state_next;
    pipeline_tail_pkg::pixel_meta_t meta;
    pipeline_tail_pkg::fb_addr_t    addr_cnt;
    pipeline_tail_pkg::fb_addr_t    wr_addr;
    logic                           accept;

    //////////////////////////////////////////////////
    // Stream acceptance and write port
    //////////////////////////////////////////////////

    assign meta        = pixel_beat.meta;
    assign pixel_ready = (state == pipeline_tail_pkg::DRAW);
    assign accept      = pixel_valid && pixel_ready;

    // A beat with sof always lands at the top left
    assign wr_addr = meta.sof ? '0 : addr_cnt;

    always_comb begin
        fb_wr.en   = accept;
        fb_wr.addr = wr_addr;
        fb_wr.data = pixel_beat.pixel;
    end

    // Next write position
    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            addr_cnt <= '0;
        end else if (accept) begin
            if (meta.eof) begin
                addr_cnt <= '0;
            end else begin
                addr_cnt <= wr_addr + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Frame done FSM
    //////////////////////////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            pipeline_tail_pkg::DRAW: begin
                if (accept && meta.eof) begin
                    state_next = pipeline_tail_pkg::REQ_SWAP;
                end
            end
            pipeline_tail_pkg::REQ_SWAP: begin
                // Hold the request until the controller answers
                if (swap_ack) begin
                    state_next = pipeline_tail_pkg::WAIT_RELEASE;
                end
            end
            pipeline_tail_pkg::WAIT_RELEASE: begin
                if (!swap_ack) begin
                    state_next = pipeline_tail_pkg::DRAW;
                end
            end
            default: begin
                state_next = pipeline_tail_pkg::DRAW;
            end
        endcase
    end

    always_ff @(posedge clk_display or negedge rstn_display) begin
        if (!rstn_display) begin
            state <= pipeline_tail_pkg::DRAW;
        end else begin
            state <= state_next;
        end
    end

    // Request is a straight decode of a registered state
    assign swap_req = (state == pipeline_tail_pkg::REQ_SWAP);

endmodule

/* source/frame_buffer.sv */
`timescale 1ns/1ps

module frame_buffer #(
    parameter int ADDR_W = 15,
    parameter int DEPTH  = 19200
) (
    input  logic                          clk_display,
    input  pipeline_tail_pkg::fb_write_t  wr,
    input  logic [ADDR_W-1:0]             rd_addr,
    output pipeline_tail_pkg::pixel_t     rd_data
);

    // Pixel storage, one word per buffer position
    pipeline_tail_pkg::pixel_t mem [DEPTH];

    logic [ADDR_W-1:0] wr_addr;

    // Only the low bits of the shared address field apply here
    assign wr_addr = wr.addr[ADDR_W-1:0];

    //////////////////////////////////////////////////
    // Write port
    //////////////////////////////////////////////////

    always_ff @(posedge clk_display) begin
        if (wr.en) begin
            mem[wr_addr] <= wr.data;
        end
    end

    //////////////////////////////////////////////////
    // Read port
    //////////////////////////////////////////////////

    // Data shows up one cycle after the address
    always_ff @(posedge clk_display) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* source/pipeline_tail_pkg.sv */
package pipeline_tail_pkg;

    //////////////////////////////////////////////////
    // Widths and plain vector types
    //////////////////////////////////////////////////

    // Widest buffer address any instance may use
    localparam int FB_ADDR_MAX_W = 16;

    // 12-bit RGB, red in the top nibble
    typedef logic [11:0] pixel_t;

    // One VGA colour channel
    typedef logic [3:0] color_t;

    // Frame buffer address at full width
    typedef logic [FB_ADDR_MAX_W-1:0] fb_addr_t;

    //////////////////////////////////////////////////
    // Stream and write port bundles
    //////////////////////////////////////////////////

    // Frame markers carried with each pixel
    typedef struct packed {
        logic sof;
        logic eof;
    } pixel_meta_t;

    // Stream payload, 14 bits
    typedef struct packed {
        pixel_t      pixel;
        pixel_meta_t meta;
    } pixel_beat_t;

    // Write port from the drawing manager to a frame buffer
    // Instances only look at the low address bits they need
    typedef struct packed {
        logic     en;
        fb_addr_t addr;
        pixel_t   data;
    } fb_write_t;

    //////////////////////////////////////////////////
    // State machines
    //////////////////////////////////////////////////

    // Drawing manager states
    // DRAW          accepting beats
    // REQ_SWAP      frame done, waiting for ack
    // WAIT_RELEASE  waiting for ack to fall
    typedef enum logic [1:0] {
        DRAW         = 2'd0,
        REQ_SWAP     = 2'd1,
        WAIT_RELEASE = 2'd2
    } draw_state_t;

endpackage
